//--- filelist.f
verilog/dcache_pkg.sv
verilog/cache_array.sv
verilog/dcache_lookup.sv
verilog/dcache_miss_queue.sv
verilog/dcache.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

//--- verification/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions import dcache_pkg::*; (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_write,
  input logic req_ready,
  input logic rd_valid,
  input logic miss_valid,
  input bus_command_t mem_command
);

  int fail_count = 0;

  // the fill owns the array write port
  miss_blocks_requests: assert property (
    @(posedge clock) disable iff (reset) miss_valid |-> !req_ready
  ) else begin
    fail_count++;
    $error("miss_valid while req_ready is high");
  end

  command_legal: assert property (
    @(posedge clock) disable iff (reset) mem_command inside {BUS_NONE, BUS_LOAD}
  ) else begin
    fail_count++;
    $error("mem_command outside its encoding");
  end

  // hit reply one cycle after the read was taken
  hit_follows_request: assert property (
    @(posedge clock) disable iff (reset)
      rd_valid |-> $past(req_valid && req_ready && !req_write)
  ) else begin
    fail_count++;
    $error("rd_valid without a read accepted the cycle before");
  end

endmodule

bind dcache dcache_assertions u_assertions (
  .clock, .reset, .req_valid, .req_write, .req_ready, .rd_valid, .miss_valid, .mem_command
);

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

  localparam int PERIOD     = 40;
  localparam int NUM_WAYS   = 4;
  localparam int NUM_SETS   = 8;
  localparam int MISS_DEPTH = 4;
  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam logic [63:0] MEM_KEY = 64'h5a5a_c3c3_0f0f_9696;
  localparam logic [1:0] K_HIT   = 2'd0;
  localparam logic [1:0] K_MISS  = 2'd1;
  localparam logic [1:0] K_WRITE = 2'd2;

  typedef struct packed {
    logic        write;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [1:0]  kind;
    logic [63:0] data;
    logic        refuse;
    logic        drain;
    logic        stall;
  } row_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic req_valid, req_write, req_ready, rd_valid, miss_valid, evicted_valid;
  logic [63:0] req_addr, req_wdata, rd_data, miss_addr, miss_data;
  logic [63:0] evicted_addr, evicted_data, mem_addr, mem_data;
  bus_command_t mem_command;
  mem_tag_t mem_response, mem_tag, next_tag;

  row_t rows[$];
  logic [63:0] exp_lines[$];
  logic [63:0] load_lines[$];
  logic [63:0] evict_addr_q[$];
  logic [63:0] evict_data_q[$];
  logic [63:0] ret_data_q[$];
  mem_tag_t ret_tag_q[$];
  int ret_due_q[$];
  logic [31:0] lfsr = 32'h5ac95e5f;
  logic mem_refuse = 1'b0;
  int checks = 0;
  int errors = 0;
  int cycle = 0;
  int load_count = 0;
  int miss_count = 0;

  // reference model of the array
  bit m_valid[NUM_SETS][NUM_WAYS];
  bit m_dirty[NUM_SETS][NUM_WAYS];
  logic [63:0] m_line[NUM_SETS][NUM_WAYS];
  logic [63:0] m_data[NUM_SETS][NUM_WAYS];
  int m_ptr[NUM_SETS];

  dcache #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .MISS_DEPTH(MISS_DEPTH)) dut (.*);

  always #(PERIOD / 2) clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [63:0] line_of(input logic [63:0] addr);
    return {32'b0, addr[31:3], 3'b0};
  endfunction

  function automatic logic [63:0] mem_value(input logic [63:0] addr);
    return line_of(addr) ^ MEM_KEY;
  endfunction

  // galois lfsr stepped once per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  function automatic bit model_hit(input logic [63:0] addr);
    int idx;
    idx = int'(addr[3 +: INDEX_BITS]);
    for (int w = 0; w < NUM_WAYS; w++)
      if (m_valid[idx][w] && m_line[idx][w] == line_of(addr))
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic model_store(input logic [63:0] addr, input logic [63:0] data, input bit fill);
    int idx;
    int way;
    idx = int'(addr[3 +: INDEX_BITS]);
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (m_valid[idx][w] && m_line[idx][w] == line_of(addr))
        way = w;
    if (way >= 0) begin
      if (!fill) begin
        m_data[idx][way] = data;
        m_dirty[idx][way] = 1'b1;
      end
      return;
    end
    // lowest invalid way, else the round-robin pointer
    for (int w = NUM_WAYS - 1; w >= 0; w--)
      if (!m_valid[idx][w])
        way = w;
    if (way < 0) begin
      way = m_ptr[idx];
      m_ptr[idx] = (m_ptr[idx] + 1) % NUM_WAYS;
      if (m_dirty[idx][way]) begin
        evict_addr_q.push_back(m_line[idx][way]);
        evict_data_q.push_back(m_data[idx][way]);
      end
    end
    m_valid[idx][way] = 1'b1;
    m_dirty[idx][way] = !fill;
    m_line[idx][way] = line_of(addr);
    m_data[idx][way] = data;
  endtask

  //////////////////////////////////////////////////
  // memory responder and output monitor
  //////////////////////////////////////////////////

  always @(negedge clock) begin
    mem_tag = '0;
    mem_response = '0;
    if (!reset && ret_tag_q.size() != 0 && cycle >= ret_due_q[0]) begin
      mem_tag = ret_tag_q.pop_front();
      mem_data = ret_data_q.pop_front();
      void'(ret_due_q.pop_front());
    end
    if (!reset && mem_command == BUS_LOAD && !mem_refuse && take_bits(1) == 1) begin
      if (load_lines.size() == 0)
        report("BUS_LOAD with no read miss waiting for one");
      else
        compare("mem_addr", mem_addr, load_lines.pop_front());
      mem_response = next_tag;
      ret_tag_q.push_back(next_tag);
      ret_data_q.push_back(mem_addr ^ MEM_KEY);
      // accepted at the next edge, returned 1 to 8 cycles later
      ret_due_q.push_back(cycle + 2 + take_bits(3));
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      load_count++;
    end
  end

  always @(negedge clock) begin
    if (!reset && miss_valid && exp_lines.size() == 0)
      report("miss_valid with no read miss outstanding");
    else if (!reset && miss_valid) begin
      compare("miss_addr", miss_addr, exp_lines[0]);
      compare("miss_data", miss_data, mem_value(exp_lines[0]));
      model_store(exp_lines[0], mem_value(exp_lines[0]), 1'b1);
      void'(exp_lines.pop_front());
    end
    if (!reset && evicted_valid && evict_addr_q.size() == 0)
      report("evicted_valid with no dirty line expected to leave");
    else if (!reset && evicted_valid) begin
      compare("evicted_addr", evicted_addr, evict_addr_q.pop_front());
      compare("evicted_data", evicted_data, evict_data_q.pop_front());
    end
  end

  task automatic apply_row(input row_t r);
    bit dup;
    int evicts;
    bit evicting;
    if (r.drain)
      while (exp_lines.size() != 0)
        @(negedge clock);
    if (r.stall)
      compare("req_ready", req_ready, 1'b0);
    mem_refuse <= r.refuse;
    while (!req_ready)
      @(negedge clock);
    dup = 1'b0;
    foreach (exp_lines[i])
      if (exp_lines[i] == line_of(r.addr))
        dup = 1'b1;
    if (!r.write)
      compare("hit", model_hit(r.addr), r.kind == K_HIT);
    req_valid = 1'b1;
    req_write = r.write;
    req_addr = r.addr;
    req_wdata = r.wdata;
    evicts = evict_addr_q.size();
    if (r.write)
      model_store(r.addr, r.wdata, 1'b0);
    else if (r.kind == K_MISS && !dup) begin
      exp_lines.push_back(line_of(r.addr));
      load_lines.push_back(line_of(r.addr));
      miss_count++;
    end
    evicting = evict_addr_q.size() != evicts;
    @(negedge clock);
    req_valid = 1'b0;
    compare("rd_valid", rd_valid, r.kind == K_HIT);
    compare("evicted_valid", evicted_valid, evicting);
    if (r.kind == K_HIT)
      compare("rd_data", rd_data, r.data);
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  initial begin
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    mem_response = '0;
    mem_tag = '0;
    mem_data = '0;
    next_tag = 4'd1;
    // write, addr, wdata, kind, data, refuse, drain, stall
    rows.push_back({1'b0, 64'h1000, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h1000, 64'h0, K_HIT, mem_value(64'h1000), 1'b0, 1'b1, 1'b0});
    rows.push_back({1'b1, 64'h2008, 64'hbeef_2008, K_WRITE, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h2008, 64'h0, K_HIT, 64'hbeef_2008, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b1, 64'h1000, 64'hbeef_1000, K_WRITE, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h1000, 64'h0, K_HIT, 64'hbeef_1000, 1'b0, 1'b0, 1'b0});
    // duplicate miss, then overlapping misses
    rows.push_back({1'b0, 64'h3010, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h3010, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h4018, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h5020, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h4018, 64'h0, K_HIT, mem_value(64'h4018), 1'b0, 1'b1, 1'b0});
    // five lines into set 7
    for (int i = 1; i <= 5; i++)
      rows.push_back({1'b1, 64'h38 + 64'(i) * 64'h10000, 64'hbeef_0000 + 64'(i), K_WRITE,
                      64'h0, 1'b0, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h20038, 64'h0, K_HIT, 64'hbeef_0002, 1'b0, 1'b0, 1'b0});
    // queue full while memory refuses loads
    rows.push_back({1'b0, 64'h6000, 64'h0, K_MISS, 64'h0, 1'b1, 1'b1, 1'b0});
    rows.push_back({1'b0, 64'h6008, 64'h0, K_MISS, 64'h0, 1'b1, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h6010, 64'h0, K_MISS, 64'h0, 1'b1, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h6018, 64'h0, K_MISS, 64'h0, 1'b1, 1'b0, 1'b0});
    rows.push_back({1'b0, 64'h7028, 64'h0, K_MISS, 64'h0, 1'b0, 1'b0, 1'b1});
    rows.push_back({1'b0, 64'h6018, 64'h0, K_HIT, mem_value(64'h6018), 1'b0, 1'b1, 1'b0});
    rows.push_back({1'b0, 64'h7028, 64'h0, K_HIT, mem_value(64'h7028), 1'b0, 1'b0, 1'b0});
    repeat (5) @(negedge clock);
    reset = 1'b0;
    compare("req_ready", req_ready, 1'b1);
    compare("rd_valid", rd_valid, 1'b0);
    compare("miss_valid", miss_valid, 1'b0);
    compare("evicted_valid", evicted_valid, 1'b0);
    compare("mem_command", mem_command, BUS_NONE);
    foreach (rows[i])
      apply_row(rows[i]);
    while (exp_lines.size() != 0)
      @(negedge clock);
    repeat (4) @(negedge clock);
    compare("load count", load_count, miss_count);
    if (evict_addr_q.size() != 0)
      report("an expected eviction was never reported");
    if (dut.u_assertions.fail_count != 0)
      report("a bound assertion failed");
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #1;
    #(rows.size() * 40 * PERIOD);
    $display("timeout: the run did not finish in time, %0d errors so far", errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- verilog/cache_array.sv
`timescale 1ns/1ps

module cache_array import dcache_pkg::*; #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic [$clog2(NUM_SETS)-1:0] rd_index,
  input  logic wr_en,
  input  logic [$clog2(NUM_SETS)-1:0] wr_index,
  input  logic [LINE_ADDR_WIDTH-$clog2(NUM_SETS)-1:0] wr_tag,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic fill_valid,
  input  logic [LINE_ADDR_WIDTH-1:0] fill_line,
  input  logic [DATA_WIDTH-1:0] fill_data,
  output logic [NUM_WAYS-1:0][LINE_ADDR_WIDTH-$clog2(NUM_SETS)-1:0] rd_tags,
  output logic [NUM_WAYS-1:0] rd_valids,
  output logic [NUM_WAYS-1:0][DATA_WIDTH-1:0] rd_data_ways,
  output logic evicted_valid,
  output logic [ADDR_WIDTH-1:0] evicted_addr,
  output logic [DATA_WIDTH-1:0] evicted_data
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = LINE_ADDR_WIDTH - INDEX_BITS;
  localparam int WAY_BITS   = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam int HIGH_BITS  = ADDR_WIDTH - LINE_ADDR_WIDTH - OFFSET_BITS;

  logic [TAG_BITS-1:0]   tag_mem  [NUM_SETS][NUM_WAYS];
  logic [DATA_WIDTH-1:0] data_mem [NUM_SETS][NUM_WAYS];
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_bits;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_bits;
  logic [NUM_SETS-1:0][WAY_BITS-1:0] rr_ptr;

  logic                  w_en;
  logic [INDEX_BITS-1:0] w_index;
  logic [TAG_BITS-1:0]   w_tag;
  logic [DATA_WIDTH-1:0] w_data;
  logic                  w_hit;
  logic [WAY_BITS-1:0]   hit_way;
  logic [WAY_BITS-1:0]   victim_way;
  logic [WAY_BITS-1:0]   w_way;
  logic [WAY_BITS-1:0]   next_ptr;
  logic                  have_invalid;
  logic                  install;
  logic                  update;
  logic                  evict_dirty;

  // combinational read of the request set
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_tags[w]      = tag_mem[rd_index][w];
      rd_valids[w]    = valid_bits[rd_index][w];
      rd_data_ways[w] = data_mem[rd_index][w];
    end
  end

  //////////////////////////////////////////////////
  // single write port shared by fill and processor
  //////////////////////////////////////////////////

  assign w_en = fill_valid || wr_en;

  always_comb begin
    if (fill_valid) begin
      w_index = fill_line[INDEX_BITS-1:0];
      w_tag   = fill_line[LINE_ADDR_WIDTH-1:INDEX_BITS];
      w_data  = fill_data;
    end else begin
      w_index = wr_index;
      w_tag   = wr_tag;
      w_data  = wr_data;
    end
  end

  always_comb begin
    w_hit        = 1'b0;
    hit_way      = '0;
    have_invalid = 1'b0;
    victim_way   = rr_ptr[w_index];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_bits[w_index][w] && tag_mem[w_index][w] == w_tag) begin
        w_hit   = 1'b1;
        hit_way = WAY_BITS'(w);
      end
    end
    // lowest invalid way wins over the pointer
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_bits[w_index][w]) begin
        have_invalid = 1'b1;
        victim_way   = WAY_BITS'(w);
      end
    end
  end

  assign w_way    = w_hit ? hit_way : victim_way;
  assign next_ptr = (rr_ptr[w_index] == WAY_BITS'(NUM_WAYS - 1)) ? '0 : rr_ptr[w_index] + 1'b1;

  // a fill of a line already present changes nothing
  assign install     = w_en && !w_hit;
  assign update      = w_en && w_hit && !fill_valid;
  assign evict_dirty = install && valid_bits[w_index][victim_way]
                       && dirty_bits[w_index][victim_way];

  always_ff @(posedge clock) begin
    if (install || update) begin
      tag_mem[w_index][w_way]  <= w_tag;
      data_mem[w_index][w_way] <= w_data;
    end
    if (evict_dirty) begin
      evicted_addr <= {{HIGH_BITS{1'b0}}, tag_mem[w_index][victim_way], w_index,
                       {OFFSET_BITS{1'b0}}};
      evicted_data <= data_mem[w_index][victim_way];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits    <= '0;
      dirty_bits    <= '0;
      rr_ptr        <= '0;
      evicted_valid <= 1'b0;
    end else begin
      evicted_valid <= evict_dirty;
      if (install || update) begin
        valid_bits[w_index][w_way] <= 1'b1;
        // processor writes leave the line dirty
        dirty_bits[w_index][w_way] <= !fill_valid;
      end
      if (install && !have_invalid) begin
        rr_ptr[w_index] <= next_ptr;
      end
    end
  end

endmodule

//--- verilog/dcache.sv
`timescale 1ns/1ps

module dcache import dcache_pkg::*; #(
  parameter int NUM_WAYS   = 4,
  parameter int NUM_SETS   = 8,
  parameter int MISS_DEPTH = 4
) (
  input  logic clock,
  input  logic reset,
  // processor side
  input  logic req_valid,
  input  logic req_write,
  input  logic [ADDR_WIDTH-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0] req_wdata,
  output logic req_ready,
  output logic rd_valid,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic miss_valid,
  output logic [ADDR_WIDTH-1:0] miss_addr,
  output logic [DATA_WIDTH-1:0] miss_data,
  output logic evicted_valid,
  output logic [ADDR_WIDTH-1:0] evicted_addr,
  output logic [DATA_WIDTH-1:0] evicted_data,
  // memory side
  output bus_command_t mem_command,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  input  mem_tag_t mem_response,
  input  mem_tag_t mem_tag,
  input  logic [DATA_WIDTH-1:0] mem_data
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = LINE_ADDR_WIDTH - INDEX_BITS;
  localparam int HIGH_BITS  = ADDR_WIDTH - LINE_ADDR_WIDTH - OFFSET_BITS;

  logic [INDEX_BITS-1:0]               rd_index;
  logic [NUM_WAYS-1:0][TAG_BITS-1:0]   rd_tags;
  logic [NUM_WAYS-1:0]                 rd_valids;
  logic [NUM_WAYS-1:0][DATA_WIDTH-1:0] rd_data_ways;

  logic                  wr_en;
  logic [INDEX_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0]   wr_tag;
  logic [DATA_WIDTH-1:0] wr_data;

  logic                       miss_push;
  logic [LINE_ADDR_WIDTH-1:0] miss_line;
  logic                       queue_full;

  logic                       fill_valid;
  logic [LINE_ADDR_WIDTH-1:0] fill_line;
  logic [DATA_WIDTH-1:0]      fill_data;

  cache_array #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) u_array (
    .clock, .reset,
    .rd_index, .wr_en, .wr_index, .wr_tag, .wr_data,
    .fill_valid, .fill_line, .fill_data,
    .rd_tags, .rd_valids, .rd_data_ways,
    .evicted_valid, .evicted_addr, .evicted_data
  );

  dcache_lookup #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) u_lookup (
    .clock, .reset,
    .req_valid, .req_write, .req_addr, .req_wdata,
    .queue_full, .fill_valid,
    .rd_tags, .rd_valids, .rd_data_ways,
    .req_ready, .rd_valid, .rd_data, .rd_index,
    .wr_en, .wr_index, .wr_tag, .wr_data,
    .miss_push, .miss_line
  );

  dcache_miss_queue #(
    .MISS_DEPTH(MISS_DEPTH)
  ) u_miss_queue (
    .clock, .reset,
    .miss_push, .miss_line,
    .mem_response, .mem_tag, .mem_data,
    .queue_full, .mem_command, .mem_addr,
    .fill_valid, .fill_line, .fill_data
  );

  // completed fills are reported as they enter the array
  assign miss_valid = fill_valid;
  assign miss_addr  = {{HIGH_BITS{1'b0}}, fill_line, {OFFSET_BITS{1'b0}}};
  assign miss_data  = fill_data;

endmodule

//--- verilog/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic req_valid,
  input  logic req_write,
  input  logic [ADDR_WIDTH-1:0] req_addr,
  input  logic [DATA_WIDTH-1:0] req_wdata,
  input  logic queue_full,
  input  logic fill_valid,
  input  logic [NUM_WAYS-1:0][LINE_ADDR_WIDTH-$clog2(NUM_SETS)-1:0] rd_tags,
  input  logic [NUM_WAYS-1:0] rd_valids,
  input  logic [NUM_WAYS-1:0][DATA_WIDTH-1:0] rd_data_ways,
  output logic req_ready,
  output logic rd_valid,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic [$clog2(NUM_SETS)-1:0] rd_index,
  output logic wr_en,
  output logic [$clog2(NUM_SETS)-1:0] wr_index,
  output logic [LINE_ADDR_WIDTH-$clog2(NUM_SETS)-1:0] wr_tag,
  output logic [DATA_WIDTH-1:0] wr_data,
  output logic miss_push,
  output logic [LINE_ADDR_WIDTH-1:0] miss_line
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = LINE_ADDR_WIDTH - INDEX_BITS;

  logic [INDEX_BITS-1:0] req_index;
  logic [TAG_BITS-1:0]   req_tag;
  logic                  accept;
  logic                  hit;
  logic [DATA_WIDTH-1:0] hit_data;

  //////////////////////////////////////////////////
  // address split and tag compare
  //////////////////////////////////////////////////

  assign req_index = req_addr[OFFSET_BITS +: INDEX_BITS];
  assign req_tag   = req_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
  assign rd_index  = req_index;

  always_comb begin
    hit      = 1'b0;
    hit_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rd_valids[w] && rd_tags[w] == req_tag) begin
        hit      = 1'b1;
        hit_data = rd_data_ways[w];
      end
    end
  end

  // fill owns the array write port while it is shown
  assign req_ready = !queue_full && !fill_valid;
  assign accept    = req_valid && req_ready;

  // writes go straight to the array
  assign wr_en    = accept && req_write;
  assign wr_index = req_index;
  assign wr_tag   = req_tag;
  assign wr_data  = req_wdata;

  assign miss_push = accept && !req_write && !hit;
  assign miss_line = req_addr[OFFSET_BITS +: LINE_ADDR_WIDTH];

  //////////////////////////////////////////////////
  // read hit reply
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= accept && !req_write && hit;
    end
  end

  always_ff @(posedge clock) begin
    if (accept && !req_write && hit) begin
      rd_data <= hit_data;
    end
  end

endmodule

//--- verilog/dcache_miss_queue.sv
`timescale 1ns/1ps

module dcache_miss_queue import dcache_pkg::*; #(
  parameter int MISS_DEPTH = 4
) (
  input  logic clock,
  input  logic reset,
  input  logic miss_push,
  input  logic [LINE_ADDR_WIDTH-1:0] miss_line,
  input  mem_tag_t mem_response,
  input  mem_tag_t mem_tag,
  input  logic [DATA_WIDTH-1:0] mem_data,
  output logic queue_full,
  output bus_command_t mem_command,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic fill_valid,
  output logic [LINE_ADDR_WIDTH-1:0] fill_line,
  output logic [DATA_WIDTH-1:0] fill_data
);

  localparam int PTR_BITS  = (MISS_DEPTH > 1) ? $clog2(MISS_DEPTH) : 1;
  localparam int HIGH_BITS = ADDR_WIDTH - LINE_ADDR_WIDTH - OFFSET_BITS;

  miss_state_t                state   [MISS_DEPTH];
  logic [LINE_ADDR_WIDTH-1:0] lines   [MISS_DEPTH];
  mem_tag_t                   tags    [MISS_DEPTH];

  // entries are allocated, sent and retired in order
  logic [PTR_BITS-1:0] head_ptr;
  logic [PTR_BITS-1:0] send_ptr;
  logic [PTR_BITS-1:0] tail_ptr;
  logic [PTR_BITS:0]   count;

  logic present;
  logic push_new;
  logic sending;
  logic accepted;
  logic done;

  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(MISS_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // duplicate check and enqueue
  //////////////////////////////////////////////////

  always_comb begin
    present = 1'b0;
    for (int i = 0; i < MISS_DEPTH; i++) begin
      if (state[i] != MISS_FREE && lines[i] == miss_line) begin
        present = 1'b1;
      end
    end
  end

  assign queue_full = (count == (PTR_BITS + 1)'(MISS_DEPTH));
  assign push_new   = miss_push && !present && !queue_full;

  //////////////////////////////////////////////////
  // load issue and tagged return
  //////////////////////////////////////////////////

  assign sending     = (state[send_ptr] == MISS_TO_SEND);
  assign mem_command = sending ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = sending ? {{HIGH_BITS{1'b0}}, lines[send_ptr], {OFFSET_BITS{1'b0}}}
                               : '0;

  // zero response means offer the same load again
  assign accepted = sending && (mem_response != '0);

  // memory answers in order, so only the head can match
  assign done = (state[head_ptr] == MISS_IN_FLIGHT) && (mem_tag != '0)
                && (mem_tag == tags[head_ptr]);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MISS_DEPTH; i++) begin
        state[i] <= MISS_FREE;
      end
      head_ptr   <= '0;
      send_ptr   <= '0;
      tail_ptr   <= '0;
      count      <= '0;
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= done;
      if (push_new) begin
        state[tail_ptr] <= MISS_TO_SEND;
        tail_ptr        <= ptr_inc(tail_ptr);
      end
      if (accepted) begin
        state[send_ptr] <= MISS_IN_FLIGHT;
        send_ptr        <= ptr_inc(send_ptr);
      end
      if (done) begin
        state[head_ptr] <= MISS_FREE;
        head_ptr        <= ptr_inc(head_ptr);
      end
      count <= count + (PTR_BITS + 1)'(push_new) - (PTR_BITS + 1)'(done);
    end
  end

  // entry payload and the registered fill
  always_ff @(posedge clock) begin
    if (push_new) begin
      lines[tail_ptr] <= miss_line;
    end
    if (accepted) begin
      tags[send_ptr] <= mem_response;
    end
    if (done) begin
      fill_line <= lines[head_ptr];
      fill_data <= mem_data;
    end
  end

endmodule

//--- verilog/dcache_pkg.sv
package dcache_pkg;

  //////////////////////////////////////////////////
  // address and data geometry
  //////////////////////////////////////////////////

  localparam int ADDR_WIDTH      = 64;
  localparam int DATA_WIDTH      = 64;
  localparam int OFFSET_BITS     = 3;
  // only address bits 31 down to 3 name a line
  localparam int LINE_ADDR_WIDTH = 29;

  // zero is reserved for no tag
  typedef logic [3:0] mem_tag_t;

  typedef enum logic [1:0] {
    BUS_NONE = 2'b00,
    BUS_LOAD = 2'b01
  } bus_command_t;

  typedef enum logic [1:0] {
    MISS_FREE      = 2'b00,
    MISS_TO_SEND   = 2'b01,
    MISS_IN_FLIGHT = 2'b10
  } miss_state_t;

endpackage
